// File: dv/scratchpad_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module scratchpad_tb import mem_pkg::*; ();

    localparam int AW = `MEM_ADDR_WIDTH + 2;  // byte address width
    localparam int RAND_OPS = 200;
    // cycle budget per test, summed for the watchdog
    localparam int RUN_CYCLES = 60 + 80 + 50 + 60 + (RAND_OPS + 100) + 100;

    logic clk, reset_reg;
    logic i_req_valid, i_resp_credit, i_req_credit, i_resp_valid;
    logic [AW-1:0] i_req_addr;
    word_t i_resp_rdata;
    logic d_req_valid, d_req_write, d_req_signed, d_resp_credit, d_req_credit, d_resp_valid;
    mem_size_t d_req_size;
    logic [AW-1:0] d_req_addr;
    word_t d_req_wdata, d_resp_rdata;

    byte_t ref_mem [2 ** AW];  // byte-wide reference model
    word_t i_exp [$];
    word_t d_exp [$];
    integer i_req_cnt, d_req_cnt;  // requester-side credits
    integer i_owed, d_owed;        // response credits still to hand back
    integer i_rx, d_rx;
    integer ret_mode;              // 0 hold, 1 every cycle, 2 random
    integer val_errs, proto_errs;
    integer seed = 32'h7e09e5c1;
    string cur_test;

    scratchpad_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            val_errs++;
        end
    endtask

    task automatic check_credits(input string name, input integer expected, input integer actual);
        if (expected != actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            val_errs++;
        end
    endtask

    task automatic report_protocol(input string msg);
        $display("%s: %s", cur_test, msg);
        proto_errs++;
    endtask

    function automatic word_t fill_word(input logic [AW-1:0] addr);
        return 32'(addr) * 32'h9e3779b1;
    endfunction

    function automatic word_t load_ref(input logic [AW-1:0] addr, input mem_size_t sz,
                                       input logic sgn);
        int a;
        byte_t b;
        logic [15:0] h;
        a = int'(addr);
        b = ref_mem[a];
        h = {ref_mem[a + 1], ref_mem[a]};  // little endian
        case (sz)
            SIZE_BYTE: return sgn ? {{24{b[7]}}, b} : {24'h0, b};
            SIZE_HALF: return sgn ? {{16{h[15]}}, h} : {16'h0, h};
            default: return {ref_mem[a + 3], ref_mem[a + 2], h};
        endcase
    endfunction

    // sample outputs mid-cycle, all of them are registered
    task automatic observe();
        if (i_resp_valid) begin
            i_rx++;
            i_owed++;
            if (i_exp.size() == 0) report_protocol("instruction response with nothing outstanding");
            else check_word({cur_test, " i_resp"}, i_exp.pop_front(), i_resp_rdata);
        end
        if (d_resp_valid) begin
            d_rx++;
            d_owed++;
            if (d_exp.size() == 0) report_protocol("data response with nothing outstanding");
            else check_word({cur_test, " d_resp"}, d_exp.pop_front(), d_resp_rdata);
        end
        if (i_req_credit) begin
            if (i_req_cnt == `REQ_CREDITS) report_protocol("extra instruction request credit");
            else i_req_cnt++;
        end
        if (d_req_credit) begin
            if (d_req_cnt == `REQ_CREDITS) report_protocol("extra data request credit");
            else d_req_cnt++;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        observe();
        i_req_valid = 1'b0;
        d_req_valid = 1'b0;
        d_req_write = 1'b0;
        i_resp_credit = 1'b0;
        d_resp_credit = 1'b0;
        if (i_owed > 0 && (ret_mode == 1 || (ret_mode == 2 && ($random(seed) & 1) == 0))) begin
            i_resp_credit = 1'b1;
            i_owed--;
        end
        if (d_owed > 0 && (ret_mode == 1 || (ret_mode == 2 && ($random(seed) & 1) == 0))) begin
            d_resp_credit = 1'b1;
            d_owed--;
        end
    endtask

    task automatic advance_until_credit(input logic need_i, input logic need_d);
        tick();
        while ((need_i && i_req_cnt == 0) || (need_d && d_req_cnt == 0)) tick();
    endtask

    task automatic send_i(input logic [AW-1:0] addr, input logic poisoned);
        i_req_valid = 1'b1;
        i_req_addr = addr;
        i_req_cnt--;
        i_exp.push_back(poisoned ? `POISON_WORD : load_ref(addr, SIZE_WORD, 1'b0));
    endtask

    task automatic send_d(input logic wr, input mem_size_t sz, input logic sgn,
                          input logic [AW-1:0] addr, input word_t wd);
        d_req_valid = 1'b1;
        d_req_write = wr;
        d_req_size = sz;
        d_req_signed = sgn;
        d_req_addr = addr;
        d_req_wdata = wd;
        d_req_cnt--;
        if (wr) begin
            for (int k = 0; k < (1 << int'(sz)); k++) ref_mem[int'(addr) + k] = wd[8*k +: 8];
            d_exp.push_back('0);  // store ack
        end else begin
            d_exp.push_back(load_ref(addr, sz, sgn));
        end
    endtask

    // a data store to the word being fetched poisons the fetch
    task automatic send_pair(input logic [AW-1:0] ia, input logic wr, input mem_size_t sz,
                             input logic sgn, input logic [AW-1:0] da, input word_t wd);
        send_i(ia, wr && (ia[AW-1:2] == da[AW-1:2]));
        send_d(wr, sz, sgn, da, wd);
    endtask

    task automatic drain();
        ret_mode = 1;
        while (i_exp.size() > 0 || d_exp.size() > 0 || i_owed > 0 || d_owed > 0) tick();
        repeat (2) tick();  // last request credits land
        check_credits({cur_test, " i credits"}, `REQ_CREDITS, i_req_cnt);
        check_credits({cur_test, " d credits"}, `REQ_CREDITS, d_req_cnt);
    endtask

    task automatic test_reset_words();
        cur_test = "reset_words";
        repeat (4) begin
            tick();
            if (i_resp_valid || d_resp_valid || i_req_credit || d_req_credit)
                report_protocol("output active right after reset");
        end
        for (int n = 0; n < 8; n++) begin
            advance_until_credit(1'b0, 1'b1);
            send_d(1'b1, SIZE_WORD, 1'b0, AW'(12'h40 + 4 * n), fill_word(AW'(12'h40 + 4 * n)));
        end
        for (int n = 0; n < 8; n++) begin
            advance_until_credit(1'b0, 1'b1);
            send_d(1'b0, SIZE_WORD, 1'b0, AW'(12'h40 + 4 * n), '0);
        end
        drain();
    endtask

    task automatic test_partial();
        cur_test = "partial";
        advance_until_credit(1'b0, 1'b1);
        send_d(1'b1, SIZE_WORD, 1'b0, 12'h200, 32'h80ff7f01);
        advance_until_credit(1'b0, 1'b1);
        send_d(1'b1, SIZE_BYTE, 1'b0, 12'h201, 32'h12345685);  // upper bytes ignored
        advance_until_credit(1'b0, 1'b1);
        send_d(1'b1, SIZE_HALF, 1'b0, 12'h202, 32'habcd8001);
        for (int off = 0; off < 4; off++) begin
            advance_until_credit(1'b0, 1'b1);
            send_d(1'b1, SIZE_BYTE, 1'b0, AW'(12'h204 + off), {24'ha5a5a5, 8'(8'h7f + 8'h81 * off)});
        end
        advance_until_credit(1'b0, 1'b1);
        send_d(1'b1, SIZE_HALF, 1'b0, 12'h204, 32'h0000ff7e);
        for (int off = 0; off < 8; off++) begin
            for (int s = 0; s < 2; s++) begin
                advance_until_credit(1'b0, 1'b1);
                send_d(1'b0, SIZE_BYTE, s[0], AW'(12'h200 + off), '0);
                if (off % 2 == 0) begin
                    advance_until_credit(1'b0, 1'b1);
                    send_d(1'b0, SIZE_HALF, s[0], AW'(12'h200 + off), '0);
                end
            end
        end
        advance_until_credit(1'b0, 1'b1);
        send_d(1'b0, SIZE_WORD, 1'b0, 12'h204, '0);
        drain();
    endtask

    task automatic test_iport();
        cur_test = "iport";
        for (int n = 0; n < 8; n++) begin
            advance_until_credit(1'b1, 1'b0);
            send_i(AW'(12'h40 + 4 * n), 1'b0);
        end
        advance_until_credit(1'b1, 1'b1);
        send_pair(12'h44, 1'b1, SIZE_WORD, 1'b0, 12'h44, 32'h600dcafe);
        advance_until_credit(1'b1, 1'b1);
        send_pair(12'h48, 1'b1, SIZE_BYTE, 1'b0, 12'h4b, 32'h0000005e);
        advance_until_credit(1'b1, 1'b1);
        send_pair(12'h50, 1'b1, SIZE_WORD, 1'b0, 12'h54, 32'h0badf00d);  // other word
        advance_until_credit(1'b1, 1'b1);
        send_pair(12'h44, 1'b0, SIZE_WORD, 1'b0, 12'h44, '0);  // shared load, clean
        advance_until_credit(1'b1, 1'b0);
        send_i(12'h48, 1'b0);
        drain();
    endtask

    task automatic test_backpressure();
        integer i0;
        integer d0;
        cur_test = "backpressure";
        ret_mode = 0;
        i0 = i_rx;
        d0 = d_rx;
        for (int n = 0; n < `REQ_CREDITS; n++) begin
            advance_until_credit(1'b1, 1'b1);
            send_pair(AW'(12'h40 + 4 * n), 1'b0, SIZE_WORD, 1'b0, AW'(12'h4c - 4 * n), '0);
        end
        repeat (12) tick();
        for (int pass = 0; pass < 2; pass++) begin  // then nothing more while held
            check_credits("backpressure i responses", `RESP_CREDITS, i_rx - i0);
            check_credits("backpressure d responses", `RESP_CREDITS, d_rx - d0);
            check_credits("backpressure i credits", `RESP_CREDITS, i_req_cnt);
            check_credits("backpressure d credits", `RESP_CREDITS, d_req_cnt);
            repeat (8) tick();
        end
        drain();
    endtask

    task automatic test_random();
        int rnd;
        logic [1:0] off;
        mem_size_t sz;
        logic [AW-1:0] ia;
        logic [AW-1:0] da;
        cur_test = "random";
        for (int n = 0; n < 16; n++) begin  // known contents in the traffic window
            advance_until_credit(1'b0, 1'b1);
            send_d(1'b1, SIZE_WORD, 1'b0, AW'(12'h300 + 4 * n), fill_word(AW'(12'h300 + 4 * n)));
        end
        ret_mode = 2;
        for (int n = 0; n < RAND_OPS; n++) begin
            tick();
            rnd = $random(seed);
            sz = mem_size_t'(2'(rnd[31:16] % 3));
            case (sz)
                SIZE_BYTE: off = rnd[11:10];
                SIZE_HALF: off = {rnd[11], 1'b0};
                default: off = 2'b00;
            endcase
            ia = AW'(12'h300 + 4 * rnd[5:2]);
            da = AW'(12'h300 + 4 * rnd[9:6] + off);
            if (rnd[0] && i_req_cnt > 0 && rnd[1] && d_req_cnt > 0)
                send_pair(ia, rnd[12], sz, rnd[13], da, $random(seed));
            else if (rnd[0] && i_req_cnt > 0)
                send_i(ia, 1'b0);
            else if (rnd[1] && d_req_cnt > 0)
                send_d(rnd[12], sz, rnd[13], da, $random(seed));
        end
        drain();
    endtask

    initial begin
        #(RUN_CYCLES * 40 + 2000);
        $display("timeout: tests still running after %0d cycles", RUN_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset_reg = 1'b1;
        {i_req_valid, i_resp_credit, d_req_valid, d_req_write, d_req_signed, d_resp_credit} = '0;
        i_req_addr = '0;
        d_req_addr = '0;
        d_req_size = SIZE_WORD;
        d_req_wdata = '0;
        i_req_cnt = `REQ_CREDITS;
        d_req_cnt = `REQ_CREDITS;
        {i_owed, d_owed, i_rx, d_rx, val_errs, proto_errs} = '0;
        ret_mode = 1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_reg = 1'b0;
        test_reset_words();
        test_partial();
        test_iport();
        test_backpressure();
        test_random();
        $display("errors: %0d value mismatches, %0d protocol errors", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the scratchpad testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module scratchpad_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vscratchpad_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q '** FAIL **' sim.log; then
    exit 1
fi
exit 0

// File: source/dual_port_bram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module dual_port_bram import mem_pkg::*; #(
    parameter int ADDR_WIDTH = `MEM_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset_reg,
    input  logic                  en,
    input  logic [3:0]            write_en_1,
    input  logic [ADDR_WIDTH-1:0] addr_1,
    input  word_t                 data_in_1,
    output word_t                 data_out_1,
    input  logic [3:0]            write_en_2,
    input  logic [ADDR_WIDTH-1:0] addr_2,
    input  word_t                 data_in_2,
    output word_t                 data_out_2
);

    localparam int MEM_WORDS = 2 ** ADDR_WIDTH;

    mem_word_u mem [MEM_WORDS];  // contents survive reset

    mem_word_u din_1;
    mem_word_u din_2;
    logic [ADDR_WIDTH-1:0] addr_q_1;
    logic [ADDR_WIDTH-1:0] addr_q_2;
    logic hazard_1;
    logic hazard_2;
    logic hazard_q_1;
    logic hazard_q_2;
    logic rst_q;  // output register reset, sync

    assign din_1 = data_in_1;
    assign din_2 = data_in_2;

    // a read loses against a write from the other port to the same word
    assign hazard_1 = (addr_1 == addr_2) && |write_en_2;
    assign hazard_2 = (addr_1 == addr_2) && |write_en_1;

    always_ff @(posedge clk) begin
        rst_q <= reset_reg;
        if (en) begin
            addr_q_1   <= addr_1;
            addr_q_2   <= addr_2;
            hazard_q_1 <= hazard_1;
            hazard_q_2 <= hazard_2;
            for (int i = 0; i < 4; i++) begin
                if (write_en_1[i]) mem[addr_1].bytes[i] <= din_1.bytes[i];
                if (write_en_2[i]) mem[addr_2].bytes[i] <= din_2.bytes[i];
            end
        end
    end

    // write-first: a later read sees the new bytes
    always_comb begin
        if (rst_q) begin
            data_out_1 = '0;
            data_out_2 = '0;
        end else begin
            data_out_1 = hazard_q_1 ? `POISON_WORD : word_t'(mem[addr_q_1]);
            data_out_2 = hazard_q_2 ? `POISON_WORD : word_t'(mem[addr_q_2]);
        end
    end

    // both ports writing one byte would leave its contents undefined
    a_no_byte_clash: assert property (@(posedge clk) disable iff (reset_reg)
        en && (addr_1 == addr_2) |-> (write_en_1 & write_en_2) == 4'b0000);

endmodule

`default_nettype wire

// File: source/load_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module load_aligner import mem_pkg::*; (
    input  word_t      rdata,
    input  mem_size_t  size,
    input  logic [1:0] offset,
    input  logic       is_signed,
    input  logic       is_store,
    output word_t      result
);

    mem_word_u  word_view;
    byte_t      sel_byte;
    logic [15:0] sel_half;

    assign word_view = rdata;
    assign sel_byte  = word_view.bytes[offset];
    assign sel_half  = word_view.halves[offset[1]];  // offset[0] is zero for halves

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                if (is_signed) begin
                    result = {{24{sel_byte[7]}}, sel_byte};
                end else begin
                    result = {24'b0, sel_byte};
                end
            end
            SIZE_HALF: begin
                if (is_signed) begin
                    result = {{16{sel_half[15]}}, sel_half};
                end else begin
                    result = {16'b0, sel_half};
                end
            end
            SIZE_WORD: result = rdata;
            default: result = '0;
        endcase

        // store ack carries no data
        if (is_store) result = '0;
    end

endmodule

`default_nettype wire

// File: source/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// word address width, 1024 words = 4 KB
`define MEM_ADDR_WIDTH 10

// entries per response queue
`define RESP_DEPTH 4

// requester starts with one credit per queue slot
`define REQ_CREDITS `RESP_DEPTH

// response credits held by the scratchpad, per port
`define RESP_CREDITS 2

// returned on an instruction read that collides with a data write
`define POISON_WORD 32'hdeadbeef

`endif

// File: source/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_ctrl import mem_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_reg,
    input  logic                       i_req_valid,
    input  logic                       i_resp_credit,
    input  logic                       d_req_valid,
    input  logic                       d_req_write,
    input  mem_size_t                  d_req_size,
    input  logic                       d_req_signed,
    input  logic [`MEM_ADDR_WIDTH+1:0] d_req_addr,
    input  logic                       d_resp_credit,
    input  logic                       i_empty,
    input  logic                       d_empty,
    output logic                       i_req_credit,
    output logic                       d_req_credit,
    output logic                       i_push,
    output logic                       d_push,
    output logic                       i_pop,
    output logic                       d_pop,
    output logic                       ram_en,
    output mem_size_t                  d_size_q,
    output logic [1:0]                 d_offset_q,
    output logic                       d_signed_q,
    output logic                       d_store_q,
    output logic [1:0]                 d_offset
);

    localparam int CNT_W = $clog2(`RESP_CREDITS + 1);
    localparam int OUT_W = $clog2(`RESP_DEPTH + 1) + 1;  // one spare bit to see overrun

    // index 0 is the instruction port, 1 the data port
    logic [1:0] req_v;
    logic [1:0] resp_cr;
    logic [1:0] pop;
    logic [1:0] req_cr;
    logic [CNT_W-1:0] resp_cnt [2];
    logic [OUT_W-1:0] outstanding [2];  // requests whose credit is still out
    logic i_inflight;
    logic d_inflight;

    assign req_v   = {d_req_valid, i_req_valid};
    assign resp_cr = {d_resp_credit, i_resp_credit};
    assign req_cr  = {d_req_credit, i_req_credit};

    assign pop[0] = !i_empty && (resp_cnt[0] != '0);
    assign pop[1] = !d_empty && (resp_cnt[1] != '0);
    assign i_pop  = pop[0];
    assign d_pop  = pop[1];

    assign ram_en   = i_req_valid || d_req_valid;
    assign d_offset = d_req_addr[1:0];
    assign i_push   = i_inflight;  // ram data is valid one cycle after accept
    assign d_push   = d_inflight;

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            i_inflight   <= 1'b0;
            d_inflight   <= 1'b0;
            i_req_credit <= 1'b0;
            d_req_credit <= 1'b0;
            for (int p = 0; p < 2; p++) begin
                resp_cnt[p]    <= CNT_W'(`RESP_CREDITS);
                outstanding[p] <= '0;
            end
        end else begin
            i_inflight   <= i_req_valid;
            d_inflight   <= d_req_valid;
            i_req_credit <= pop[0];  // credit back the cycle after the pop
            d_req_credit <= pop[1];
            for (int p = 0; p < 2; p++) begin
                resp_cnt[p]    <= resp_cnt[p] - CNT_W'(pop[p]) + CNT_W'(resp_cr[p]);
                outstanding[p] <= outstanding[p] + OUT_W'(req_v[p]) - OUT_W'(req_cr[p]);
            end
        end
    end

    // in-flight data-side record, consumed by the aligner
    always_ff @(posedge clk) begin
        if (d_req_valid) begin
            d_size_q   <= d_req_size;
            d_offset_q <= d_req_addr[1:0];
            d_signed_q <= d_req_signed;
            d_store_q  <= d_req_write;
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_chk
        // requester returned more response credits than it was given
        a_resp_cnt_max: assert property (@(posedge clk) disable iff (reset_reg)
            resp_cnt[p] <= CNT_W'(`RESP_CREDITS));
        // queue entries plus in-flight never outnumber the slots,
        // so a push never lands on a full queue
        a_no_oversubscribe: assert property (@(posedge clk) disable iff (reset_reg)
            outstanding[p] <= OUT_W'(`RESP_DEPTH));
    end

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // data-port access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    // one word, decoded as byte lanes or as half lanes
    typedef union packed {
        byte_t [3:0]       bytes;   // bytes[0] at byte offset 0
        logic [1:0][15:0]  halves;  // halves[0] at byte offset 0
    } mem_word_u;

endpackage

`default_nettype wire

// File: source/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset_reg,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head  = slots[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) slots[wr_ptr] <= push_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset_reg) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset_reg) pop |-> !empty);

endmodule

`default_nettype wire

// File: source/scratchpad_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module scratchpad_top import mem_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_reg,
    input  logic                       i_req_valid,
    input  logic [`MEM_ADDR_WIDTH+1:0] i_req_addr,
    input  logic                       i_resp_credit,
    output logic                       i_req_credit,
    output logic                       i_resp_valid,
    output word_t                      i_resp_rdata,
    input  logic                       d_req_valid,
    input  logic                       d_req_write,
    input  mem_size_t                  d_req_size,
    input  logic                       d_req_signed,
    input  logic [`MEM_ADDR_WIDTH+1:0] d_req_addr,
    input  word_t                      d_req_wdata,
    input  logic                       d_resp_credit,
    output logic                       d_req_credit,
    output logic                       d_resp_valid,
    output word_t                      d_resp_rdata
);

    logic i_push, d_push, i_pop, d_pop, i_empty, d_empty, ram_en;
    mem_size_t d_size_q;
    logic [1:0] d_offset_q, d_offset;
    logic d_signed_q, d_store_q, d_store;
    logic [3:0] d_lane_en;
    word_t d_lane_data, d_ram_out, i_ram_out, d_aligned;

    assign d_store      = d_req_valid && d_req_write;
    assign i_resp_valid = i_pop;  // a pop is the response beat
    assign d_resp_valid = d_pop;

    mem_ctrl u_ctrl (
        .clk, .reset_reg, .i_req_valid, .i_resp_credit, .d_req_valid, .d_req_write,
        .d_req_size, .d_req_signed, .d_req_addr, .d_resp_credit, .i_empty, .d_empty,
        .i_req_credit, .d_req_credit, .i_push, .d_push, .i_pop, .d_pop, .ram_en,
        .d_size_q, .d_offset_q, .d_signed_q, .d_store_q, .d_offset
    );

    store_formatter u_fmt (
        .write(d_store), .size(d_req_size), .offset(d_offset), .wdata(d_req_wdata),
        .lane_en(d_lane_en), .lane_data(d_lane_data)
    );

    // port 1 is the data side, port 2 the read-only instruction side
    dual_port_bram #(.ADDR_WIDTH(`MEM_ADDR_WIDTH)) u_ram (
        .clk, .reset_reg, .en(ram_en),
        .write_en_1(d_lane_en), .addr_1(d_req_addr[`MEM_ADDR_WIDTH+1:2]),
        .data_in_1(d_lane_data), .data_out_1(d_ram_out),
        .write_en_2(4'b0000), .addr_2(i_req_addr[`MEM_ADDR_WIDTH+1:2]),
        .data_in_2('0), .data_out_2(i_ram_out)
    );

    load_aligner u_align (
        .rdata(d_ram_out), .size(d_size_q), .offset(d_offset_q),
        .is_signed(d_signed_q), .is_store(d_store_q), .result(d_aligned)
    );

    resp_fifo #(.WIDTH(32), .DEPTH(`RESP_DEPTH)) i_fifo (
        .clk, .reset_reg, .push(i_push), .push_data(i_ram_out), .pop(i_pop),
        .head(i_resp_rdata), .empty(i_empty), .full()
    );

    resp_fifo #(.WIDTH(32), .DEPTH(`RESP_DEPTH)) d_fifo (
        .clk, .reset_reg, .push(d_push), .push_data(d_aligned), .pop(d_pop),
        .head(d_resp_rdata), .empty(d_empty), .full()
    );

endmodule

`default_nettype wire

// File: source/store_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module store_formatter import mem_pkg::*; (
    input  logic      write,
    input  mem_size_t size,
    input  logic [1:0] offset,
    input  word_t     wdata,
    output logic [3:0] lane_en,
    output word_t     lane_data
);

    mem_word_u lanes;

    always_comb begin
        lanes = wdata;
        lane_en = 4'b0000;
        case (size)
            SIZE_BYTE: begin
                lanes.bytes = {4{wdata[7:0]}};  // low byte on every lane
                lane_en = 4'b0001 << offset;
            end
            SIZE_HALF: begin
                lanes.halves = {2{wdata[15:0]}};
                lane_en = 4'b0011 << offset;  // offset is 0 or 2
            end
            SIZE_WORD: lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
        if (!write) lane_en = 4'b0000;  // loads never touch the array
    end

    assign lane_data = lanes;

    // misaligned stores are illegal on this port
    always_comb begin
        if (write) begin
            a_aligned: assert ((size == SIZE_BYTE)
                || (size == SIZE_HALF && !offset[0])
                || (size == SIZE_WORD && offset == 2'b00));
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/mem_pkg.sv
source/dual_port_bram.sv
source/store_formatter.sv
source/load_aligner.sv
source/resp_fifo.sv
source/mem_ctrl.sv
source/scratchpad_top.sv
dv/scratchpad_tb.sv
